// ==== src.f ====
src/vid_pkg.sv
src/vid_wb_regs.sv
src/vid_axis_counter.sv
src/vid_timing_gen.sv
src/vid_frame_rate.sv
src/vid_ctrl_top.sv
verif/tb_vid_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vid_ctrl -f src.f \
	--Mdir obj_dir -o sim_vid_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_vid_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== verif/tb_vid_ctrl.sv ====
/* Drives the controller through the bus with a 28x10 test mode.
   Uses the package TICK_CYCLES, so a long tick slows the rate check. */
`default_nettype none

module tb_vid_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_TIMEOUT   = 20;
	localparam int FRAME_TIMEOUT = 1000;
	localparam int TICK          = vid_pkg::TICK_CYCLES;

	// Register word addresses
	localparam logic [4:0] A_CTL   = 5'h00;
	localparam logic [4:0] A_SIZE  = 5'h08;
	localparam logic [4:0] A_PORCH = 5'h09;
	localparam logic [4:0] A_SYNC  = 5'h0a;
	localparam logic [4:0] A_RAW   = 5'h0b;
	localparam logic [4:0] A_FPS   = 5'h0f;

	logic        i_clk;
	logic        i_pxpll_locked;
	logic        i_wb_cyc;
	logic        i_wb_stb;
	logic        i_wb_we;
	logic [4:0]  i_wb_addr;
	logic [31:0] i_wb_data;
	logic [3:0]  i_wb_sel;
	wire         o_wb_stall;
	wire         o_wb_ack;
	wire  [31:0] o_wb_data;
	wire  [1:0]  o_pxclk_sel;
	wire         o_pix_reset_n;
	wire         o_de;
	wire         o_hsync;
	wire         o_vsync;
	wire         o_hlast;
	wire         o_vlast;

	int checks;
	int errors;
	// Counters fed by the posedge monitor
	int de_cnt;
	int vlast_cnt;
	int low_cnt;

	vid_ctrl_top UUT (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_wb_sel(i_wb_sel),
		.o_wb_stall(o_wb_stall), .o_wb_ack(o_wb_ack), .o_wb_data(o_wb_data),
		.o_pxclk_sel(o_pxclk_sel), .o_pix_reset_n(o_pix_reset_n),
		.o_de(o_de), .o_hsync(o_hsync), .o_vsync(o_vsync),
		.o_hlast(o_hlast), .o_vlast(o_vlast)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = !i_clk;
	end

	// Activity counters, sampled before the outputs update
	always @(posedge i_clk) begin
		if (o_de)
			de_cnt++;
		if (o_vlast)
			vlast_cnt++;
		if (!o_pix_reset_n)
			low_cnt++;
	end

	////////////////////
	// Concurrent checks
	////////////////////

	a_no_stall: assert property (@(posedge i_clk) !o_wb_stall)
		else begin
			errors++;
			$display("FAILED at %0t: stall rose", $time);
		end

	// Ack only inside a cycle
	a_ack_in_cyc: assert property (@(posedge i_clk) !o_wb_ack || i_wb_cyc)
		else begin
			errors++;
			$display("FAILED at %0t: ack without cyc", $time);
		end

	a_hlast_de: assert property (@(posedge i_clk) disable iff (!i_pxpll_locked)
			!o_hlast || o_de)
		else begin
			errors++;
			$display("FAILED at %0t: hlast outside de", $time);
		end

	// End of frame sits on the last pixel of a line
	a_vlast_pos: assert property (@(posedge i_clk) disable iff (!i_pxpll_locked)
			!o_vlast || (o_de && o_hlast))
		else begin
			errors++;
			$display("FAILED at %0t: vlast not on last de pixel", $time);
		end

	////////////////////
	// Helpers
	////////////////////

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("FAILED at %0t: %s", $time, msg);
		end
	endtask

	task automatic end_on_timeout(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic bus_write(input logic [4:0] addr, input logic [31:0] data,
			input logic [3:0] sel);
		int waited;
		waited = 0;
		@(negedge i_clk);
		i_wb_cyc  = 1'b1;
		i_wb_stb  = 1'b1;
		i_wb_we   = 1'b1;
		i_wb_addr = addr;
		i_wb_data = data;
		i_wb_sel  = sel;
		@(negedge i_clk);
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		while (!o_wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_wb_ack)
			end_on_timeout("write ack");
		check(waited == 1, $sformatf("write ack after %0d extra cycles", waited));
		// Cycle stays up through the edge that takes the ack
		@(negedge i_clk);
		i_wb_cyc = 1'b0;
	endtask

	task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
		int waited;
		waited = 0;
		@(negedge i_clk);
		i_wb_cyc  = 1'b1;
		i_wb_stb  = 1'b1;
		i_wb_we   = 1'b0;
		i_wb_addr = addr;
		i_wb_sel  = 4'hf;
		@(negedge i_clk);
		i_wb_stb = 1'b0;
		while (!o_wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge i_clk);
			waited++;
		end
		if (!o_wb_ack)
			end_on_timeout("read ack");
		check(waited == 1, $sformatf("read ack after %0d extra cycles", waited));
		data = o_wb_data;
		@(negedge i_clk);
		i_wb_cyc = 1'b0;
	endtask

	task automatic read_expect(input logic [4:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		bus_read(addr, got);
		check(got == exp, $sformatf("addr %0h read %h, expected %h", addr, got, exp));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge i_clk);
	endtask

	task automatic wait_vlast();
		int n;
		n = 0;
		do begin
			@(negedge i_clk);
			n++;
		end while (!o_vlast && n < FRAME_TIMEOUT);
		if (!o_vlast)
			end_on_timeout("end of frame");
	endtask

	// First line of a frame, indexed from its first de cycle
	task automatic check_line(input bit hpol);
		int n;
		int de_n;
		int hs_n;
		n = 0;
		de_n = 0;
		hs_n = 0;
		wait_vlast();
		// Step off the last pixel of the old frame
		@(negedge i_clk);
		while (!o_de && n < FRAME_TIMEOUT) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_de)
			end_on_timeout("first de of frame");
		for (int i = 0; i < 28; i++) begin
			if (o_de) begin
				de_n++;
				check(i < 16, $sformatf("de at pixel %0d", i));
			end
			if (o_hlast)
				check(i == 15, $sformatf("hlast at pixel %0d", i));
			if (o_hsync == hpol) begin
				hs_n++;
				check(i >= 19 && i <= 22, $sformatf("hsync at pixel %0d", i));
			end
			@(negedge i_clk);
		end
		check(de_n == 16, $sformatf("line had %0d de cycles", de_n));
		check(hs_n == 4, $sformatf("line had %0d hsync cycles", hs_n));
		check(o_de == 1'b1, "next line did not start after 28 cycles");
	endtask

	// One whole frame, from one vlast to the next
	task automatic check_frame(input bit hpol, input bit vpol);
		int n;
		int de_n;
		int hl_n;
		int hs_n;
		int vs_n;
		n = 0;
		de_n = 0;
		hl_n = 0;
		hs_n = 0;
		vs_n = 0;
		wait_vlast();
		do begin
			@(negedge i_clk);
			n++;
			de_n += int'(o_de);
			hl_n += int'(o_hlast);
			hs_n += int'(o_hsync == hpol);
			vs_n += int'(o_vsync == vpol);
		end while (!o_vlast && n < FRAME_TIMEOUT);
		if (!o_vlast)
			end_on_timeout("next end of frame");
		check(n == 280, $sformatf("frame lasted %0d cycles", n));
		check(de_n == 96, $sformatf("frame had %0d de cycles", de_n));
		check(hl_n == 6, $sformatf("frame had %0d active lines", hl_n));
		check(hs_n == 40, $sformatf("frame had %0d hsync cycles", hs_n));
		check(vs_n == 56, $sformatf("frame had %0d vsync cycles", vs_n));
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		#2ms;
		end_on_timeout("end of the run");
	end

	initial begin
		logic [31:0] d1;
		logic [31:0] d2;
		logic [31:0] mask;
		logic [31:0] got;
		logic [4:0]  addr;
		int          meas;
		int          fps;

		checks = 0;
		errors = 0;
		de_cnt = 0;
		vlast_cnt = 0;
		low_cnt = 0;
		i_pxpll_locked = 1'b0;
		i_wb_cyc  = 1'b0;
		i_wb_stb  = 1'b0;
		i_wb_we   = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_wb_sel  = '0;
		void'($urandom(32'h3b21));

		repeat (10) @(negedge i_clk);
		i_pxpll_locked = 1'b1;
		wait_cycles(3);

		// Reset values
		read_expect(A_CTL, 32'h0000_0003);
		read_expect(A_SIZE, 32'h0);
		read_expect(A_PORCH, 32'h0);
		read_expect(A_SYNC, 32'h8000_8000);
		read_expect(A_RAW, 32'h0);
		read_expect(A_FPS, 32'h0);
		check(!o_pix_reset_n, "pixel reset released after reset");
		check(de_cnt == 0, "de rose while idle after reset");

		// Full selects, then partial selects per half
		for (int r = 0; r < 8; r++) begin
			addr = 5'h08 + 5'(r % 4);
			mask = (addr == A_SYNC) ? 32'h8fff_8fff : 32'h0fff_0fff;
			d1 = $urandom;
			d2 = $urandom;
			bus_write(addr, d1, 4'hf);
			read_expect(addr, d1 & mask);
			// Low half complete, high half missing a byte
			bus_write(addr, d2, 4'b0111);
			read_expect(addr, {d1[31:16], d2[15:0]} & mask);
			bus_write(addr, d1, 4'b1110);
			read_expect(addr, {d1[31:16], d2[15:0]} & mask);
		end
		bus_write(5'h05, $urandom, 4'hf);
		read_expect(5'h05, 32'h0);

		// Test mode, both polarities high
		bus_write(A_SIZE, 32'h0006_0010, 4'hf);
		bus_write(A_PORCH, 32'h0001_0003, 4'hf);
		bus_write(A_SYNC, 32'h8002_8004, 4'hf);
		bus_write(A_RAW, 32'h000a_001c, 4'hf);
		check(de_cnt == 0, "de rose before the request was cleared");

		// Release the video
		bus_write(A_CTL, 32'h0, 4'h1);
		wait_cycles(2);
		check(o_pix_reset_n, "pixel reset still held after clearing request");

		// Clock select change gives a single reset cycle
		low_cnt = 0;
		bus_write(A_CTL, 32'h10, 4'h1);
		wait_cycles(4);
		check(o_pxclk_sel == 2'd1, $sformatf("pxclk_sel is %0d", o_pxclk_sel));
		check(low_cnt == 1, $sformatf("reset pulse lasted %0d cycles", low_cnt));
		check(o_pix_reset_n, "pixel reset held after clock select change");
		read_expect(A_CTL, 32'h0000_0012);

		// Request set keeps the raster idle
		bus_write(A_CTL, 32'h11, 4'h1);
		wait_cycles(3);
		de_cnt = 0;
		wait_cycles(100);
		check(!o_pix_reset_n, "pixel reset not held by request");
		check(de_cnt == 0, $sformatf("%0d de cycles while idle", de_cnt));
		bus_write(A_CTL, 32'h10, 4'h1);

		// Timing at the reset polarities
		check_line(1'b1);
		check_frame(1'b1, 1'b1);

		// Inverted sync polarities
		bus_write(A_SYNC, 32'h0002_0004, 4'hf);
		wait_vlast();
		check_line(1'b0);
		check_frame(1'b0, 1'b0);

		// Frame rate over one interval
		wait_cycles(TICK);
		vlast_cnt = 0;
		wait_cycles(TICK);
		meas = vlast_cnt;
		wait_cycles(TICK);
		bus_read(A_FPS, got);
		fps = int'(got);
		check(meas >= 17 && meas <= 18, $sformatf("counted %0d frames", meas));
		check(fps >= meas - 1 && fps <= meas + 1,
			$sformatf("fps reads %0d, counted %0d", fps, meas));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/vid_ctrl_top.sv ====
/* Single clock; i_pxpll_locked doubles as the asynchronous active-low reset. */
`default_nettype none

module vid_ctrl_top (
	input  wire                          i_clk,
	input  wire                          i_pxpll_locked,
	// Bus slave
	input  wire                          i_wb_cyc,
	input  wire                          i_wb_stb,
	input  wire                          i_wb_we,
	input  wire  [vid_pkg::ADDR_W-1:0]   i_wb_addr,
	input  wire  [vid_pkg::WB_DW-1:0]    i_wb_data,
	input  wire  [vid_pkg::WB_SELW-1:0]  i_wb_sel,
	output wire                          o_wb_stall,
	output wire                          o_wb_ack,
	output wire  [vid_pkg::WB_DW-1:0]    o_wb_data,
	// Clock control
	output wire  [vid_pkg::CKSEL_W-1:0]  o_pxclk_sel,
	output wire                          o_pix_reset_n,
	// Raster
	output wire                          o_de,
	output wire                          o_hsync,
	output wire                          o_vsync,
	output wire                          o_hlast,
	output wire                          o_vlast
);
	import vid_pkg::*;

	logic             pix_reset;
	logic [FPS_W-1:0] fps;
	logic [LGDIM-1:0] h_width, h_front, h_synch, h_raw;
	logic [LGDIM-1:0] v_height, v_front, v_synch, v_raw;
	logic             h_syncpol, v_syncpol;

	assign o_pix_reset_n = !pix_reset;

	vid_wb_regs u_regs (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data), .i_wb_sel(i_wb_sel),
		.o_wb_stall(o_wb_stall), .o_wb_ack(o_wb_ack), .o_wb_data(o_wb_data),
		.i_fps(fps),
		.o_pxclk_sel(o_pxclk_sel), .o_pix_reset(pix_reset),
		.o_h_width(h_width), .o_h_front(h_front), .o_h_synch(h_synch),
		.o_h_raw(h_raw), .o_h_syncpol(h_syncpol),
		.o_v_height(v_height), .o_v_front(v_front), .o_v_synch(v_synch),
		.o_v_raw(v_raw), .o_v_syncpol(v_syncpol)
	);

	vid_timing_gen u_timing (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked), .i_pix_reset(pix_reset),
		.i_h_width(h_width), .i_h_front(h_front), .i_h_synch(h_synch),
		.i_h_raw(h_raw), .i_h_syncpol(h_syncpol),
		.i_v_height(v_height), .i_v_front(v_front), .i_v_synch(v_synch),
		.i_v_raw(v_raw), .i_v_syncpol(v_syncpol),
		.o_de(o_de), .o_hsync(o_hsync), .o_vsync(o_vsync),
		.o_hlast(o_hlast), .o_vlast(o_vlast)
	);

	// End of frame is the vlast pixel
	vid_frame_rate u_rate (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked), .i_pix_reset(pix_reset),
		.i_frame_end(o_vlast),
		.o_fps(fps)
	);

endmodule

`default_nettype wire

// ==== src/vid_frame_rate.sv ====
/* Counts frame ends per TICK_CYCLES interval; reads 255 once 256 or more frames land. */
`default_nettype none

module vid_frame_rate (
	input  wire                        i_clk,
	input  wire                        i_pxpll_locked,
	input  wire                        i_pix_reset,
	input  wire                        i_frame_end,
	output logic [vid_pkg::FPS_W-1:0]  o_fps
);
	import vid_pkg::*;

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;
	// Top bit marks saturation
	logic [FPS_W:0]    frame_cnt;

	////////////////////
	// Interval tick
	////////////////////

	// Free running, independent of pixel reset
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else if (tick_cnt == TICK_W'(TICK_CYCLES - 1)) begin
			tick_cnt <= '0;
			tick     <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick     <= 1'b0;
		end
	end

	////////////////////
	// Frame counter
	////////////////////

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			frame_cnt <= '0;
		else if (i_pix_reset)
			frame_cnt <= '0;
		else if (tick)
			// A frame ending on the tick counts toward the next interval
			frame_cnt <= i_frame_end ? (FPS_W + 1)'(1) : '0;
		else if (i_frame_end && !frame_cnt[FPS_W])
			frame_cnt <= frame_cnt + 1'b1;
	end

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			o_fps <= '0;
		else if (i_pix_reset)
			o_fps <= '0;
		else if (tick)
			o_fps <= frame_cnt[FPS_W] ? {FPS_W{1'b1}} : frame_cnt[FPS_W-1:0];
	end

endmodule

`default_nettype wire

// ==== src/vid_timing_gen.sv ====
/* Free-running raster, no back-pressure; outputs trail the counters by one clock.
   Assumes width < raw so each line has blanking after the last active pixel. */
`default_nettype none

module vid_timing_gen (
	input  wire                        i_clk,
	input  wire                        i_pxpll_locked,
	input  wire                        i_pix_reset,
	input  wire  [vid_pkg::LGDIM-1:0]  i_h_width,
	input  wire  [vid_pkg::LGDIM-1:0]  i_h_front,
	input  wire  [vid_pkg::LGDIM-1:0]  i_h_synch,
	input  wire  [vid_pkg::LGDIM-1:0]  i_h_raw,
	input  wire                        i_h_syncpol,
	input  wire  [vid_pkg::LGDIM-1:0]  i_v_height,
	input  wire  [vid_pkg::LGDIM-1:0]  i_v_front,
	input  wire  [vid_pkg::LGDIM-1:0]  i_v_synch,
	input  wire  [vid_pkg::LGDIM-1:0]  i_v_raw,
	input  wire                        i_v_syncpol,
	output logic                       o_de,
	output logic                       o_hsync,
	output logic                       o_vsync,
	output logic                       o_hlast,
	output logic                       o_vlast
);

	// Lookahead flags from the counters
	logic h_act_nxt, h_sync_nxt, h_wrap;
	logic v_act_nxt, v_sync_nxt;
	// Flags of the current position
	logic h_act, h_sync, v_act, v_sync;
	logic line_end;

	// Pixels, one step per clock
	vid_axis_counter u_hcount (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked), .i_pix_reset(i_pix_reset),
		.i_step(1'b1),
		.i_active_len(i_h_width), .i_front(i_h_front), .i_synch(i_h_synch),
		.i_raw(i_h_raw), .i_syncpol(i_h_syncpol),
		.o_active(h_act_nxt), .o_sync(h_sync_nxt), .o_wrap(h_wrap)
	);

	// Lines, stepped at each pixel wrap
	vid_axis_counter u_vcount (
		.i_clk(i_clk), .i_pxpll_locked(i_pxpll_locked), .i_pix_reset(i_pix_reset),
		.i_step(h_wrap),
		.i_active_len(i_v_height), .i_front(i_v_front), .i_synch(i_v_synch),
		.i_raw(i_v_raw), .i_syncpol(i_v_syncpol),
		.o_active(v_act_nxt), .o_sync(v_sync_nxt), .o_wrap()
	);

	// Capture lookahead as it becomes current
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			{h_act, h_sync, v_act, v_sync} <= '0;
		end else if (i_pix_reset) begin
			// Idle levels, so the first output cycle stays blank
			h_act  <= 1'b0;
			v_act  <= 1'b0;
			h_sync <= !i_h_syncpol;
			v_sync <= !i_v_syncpol;
		end else begin
			h_act  <= h_act_nxt;
			h_sync <= h_sync_nxt;
			if (h_wrap) begin
				v_act  <= v_act_nxt;
				v_sync <= v_sync_nxt;
			end
		end
	end

	// Last active pixel: active now, blank next
	assign line_end = h_act && v_act && !h_act_nxt;

	////////////////////
	// Video outputs
	////////////////////

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			{o_de, o_hlast, o_vlast, o_hsync, o_vsync} <= '0;
		end else if (i_pix_reset) begin
			{o_de, o_hlast, o_vlast} <= '0;
			o_hsync <= !i_h_syncpol;
			o_vsync <= !i_v_syncpol;
		end else begin
			o_de    <= h_act && v_act;
			o_hlast <= line_end;
			// Next line blank, so this is the frame's last pixel
			o_vlast <= line_end && !v_act_nxt;
			o_hsync <= h_sync;
			o_vsync <= v_sync;
		end
	end

endmodule

`default_nettype wire

// ==== src/vid_axis_counter.sv ====
/* Flags describe the position after the next step, not the current one.
   Held at raw-1 during pixel reset, so the first step lands on 0. */
`default_nettype none

module vid_axis_counter (
	input  wire                        i_clk,
	input  wire                        i_pxpll_locked,
	input  wire                        i_pix_reset,
	input  wire                        i_step,
	input  wire  [vid_pkg::LGDIM-1:0]  i_active_len,
	input  wire  [vid_pkg::LGDIM-1:0]  i_front,
	input  wire  [vid_pkg::LGDIM-1:0]  i_synch,
	input  wire  [vid_pkg::LGDIM-1:0]  i_raw,
	input  wire                        i_syncpol,
	output logic                       o_active,
	output logic                       o_sync,
	output logic                       o_wrap
);
	import vid_pkg::*;

	logic [LGDIM-1:0] pos;
	logic [LGDIM-1:0] last_idx;
	logic             at_last;
	logic [LGDIM-1:0] pos_step;
	// One extra bit so the sync window sums cannot wrap
	logic [LGDIM:0]   sync_start;
	logic [LGDIM:0]   sync_end;
	logic             in_sync;

	assign last_idx = i_raw - 1'b1;
	assign at_last  = (pos == last_idx);
	// Position reached by the next step
	assign pos_step = at_last ? '0 : pos + 1'b1;

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			pos <= '0;
		else if (i_pix_reset)
			pos <= last_idx;
		else if (i_step)
			pos <= pos_step;
	end

	// Steps the next axis on the same edge we return to 0
	assign o_wrap = i_step && at_last;

	////////////////////
	// Lookahead flags
	////////////////////

	// Active region first
	assign o_active = (pos_step < i_active_len);

	// Sync window after the front porch
	assign sync_start = {1'b0, i_active_len} + {1'b0, i_front};
	assign sync_end   = sync_start + {1'b0, i_synch};
	assign in_sync    = ({1'b0, pos_step} >= sync_start)
			&& ({1'b0, pos_step} < sync_end);

	// Asserted level equals the polarity bit
	assign o_sync = in_sync ? i_syncpol : !i_syncpol;

endmodule

`default_nettype wire

// ==== src/vid_wb_regs.sv ====
/* Wishbone slave with a fixed two-cycle ack; stall never rises.
   A dimension half is written only when both of its byte selects are set. */
`default_nettype none

module vid_wb_regs (
	input  wire                          i_clk,
	input  wire                          i_pxpll_locked,
	// Bus slave
	input  wire                          i_wb_cyc,
	input  wire                          i_wb_stb,
	input  wire                          i_wb_we,
	input  wire  [vid_pkg::ADDR_W-1:0]   i_wb_addr,
	input  wire  [vid_pkg::WB_DW-1:0]    i_wb_data,
	input  wire  [vid_pkg::WB_SELW-1:0]  i_wb_sel,
	output wire                          o_wb_stall,
	output logic                         o_wb_ack,
	output logic [vid_pkg::WB_DW-1:0]    o_wb_data,
	// Measured rate
	input  wire  [vid_pkg::FPS_W-1:0]    i_fps,
	// Clock and pixel reset control
	output logic [vid_pkg::CKSEL_W-1:0]  o_pxclk_sel,
	output logic                         o_pix_reset,
	// Commanded mode
	output logic [vid_pkg::LGDIM-1:0]    o_h_width,
	output logic [vid_pkg::LGDIM-1:0]    o_h_front,
	output logic [vid_pkg::LGDIM-1:0]    o_h_synch,
	output logic [vid_pkg::LGDIM-1:0]    o_h_raw,
	output logic                         o_h_syncpol,
	output logic [vid_pkg::LGDIM-1:0]    o_v_height,
	output logic [vid_pkg::LGDIM-1:0]    o_v_front,
	output logic [vid_pkg::LGDIM-1:0]    o_v_synch,
	output logic [vid_pkg::LGDIM-1:0]    o_v_raw,
	output logic                         o_v_syncpol
);
	import vid_pkg::*;

	logic               locked_pipe;
	logic               locked_sys;
	logic               pix_req;
	logic               pix_reset_nxt;
	logic               pre_ack;
	logic [WB_DW-1:0]   pre_data;
	logic [WB_DW-1:0]   rd_data;
	reg_addr_t          addr;
	logic               bus_wr;
	logic               ctl_wr;
	logic               lo_half;
	logic               hi_half;
	logic [CKSEL_W-1:0] new_cksel;

	assign addr      = reg_addr_t'(i_wb_addr);
	assign bus_wr    = i_wb_cyc && i_wb_stb && i_wb_we;
	assign ctl_wr    = bus_wr && (addr == ADR_CONTROL) && i_wb_sel[0];
	// Both bytes of a 16-bit half
	assign lo_half   = &i_wb_sel[1:0];
	assign hi_half   = &i_wb_sel[3:2];
	assign new_cksel = i_wb_data[CTL_CKSEL_LSB +: CKSEL_W];

	////////////////////
	// Lock synchronizer
	////////////////////

	// Lock seen two clocks after it rises
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			locked_pipe <= 1'b0;
			locked_sys  <= 1'b0;
		end else begin
			locked_pipe <= 1'b1;
			locked_sys  <= locked_pipe;
		end
	end

	////////////////////
	// Register writes
	////////////////////

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			// Video idle until software clears the request
			pix_req     <= 1'b1;
			o_pxclk_sel <= '0;
			o_h_width   <= '0;
			o_h_front   <= '0;
			o_h_synch   <= '0;
			o_h_raw     <= '0;
			o_h_syncpol <= 1'b1;
			o_v_height  <= '0;
			o_v_front   <= '0;
			o_v_synch   <= '0;
			o_v_raw     <= '0;
			o_v_syncpol <= 1'b1;
		end else if (bus_wr) begin
			case (addr)
			ADR_CONTROL: begin
				if (i_wb_sel[0]) begin
					pix_req     <= i_wb_data[CTL_RESET_BIT];
					o_pxclk_sel <= new_cksel;
				end
			end
			ADR_SIZE: begin
				if (lo_half)
					o_h_width <= i_wb_data[HFIELD_LSB +: LGDIM];
				if (hi_half)
					o_v_height <= i_wb_data[VFIELD_LSB +: LGDIM];
			end
			ADR_PORCH: begin
				if (lo_half)
					o_h_front <= i_wb_data[HFIELD_LSB +: LGDIM];
				if (hi_half)
					o_v_front <= i_wb_data[VFIELD_LSB +: LGDIM];
			end
			ADR_SYNC: begin
				// Polarity rides in the top bit of each half
				if (lo_half) begin
					o_h_synch   <= i_wb_data[HFIELD_LSB +: LGDIM];
					o_h_syncpol <= i_wb_data[HPOL_BIT];
				end
				if (hi_half) begin
					o_v_synch   <= i_wb_data[VFIELD_LSB +: LGDIM];
					o_v_syncpol <= i_wb_data[VPOL_BIT];
				end
			end
			ADR_RAW: begin
				if (lo_half)
					o_h_raw <= i_wb_data[HFIELD_LSB +: LGDIM];
				if (hi_half)
					o_v_raw <= i_wb_data[VFIELD_LSB +: LGDIM];
			end
			default: begin
			end
			endcase
		end
	end

	////////////////////
	// Pixel reset
	////////////////////

	// Held by the request or lost lock
	// A clock select change forces one extra reset cycle
	always_comb begin
		pix_reset_nxt = pix_req || !locked_sys;
		if (ctl_wr && ((new_cksel != o_pxclk_sel) || i_wb_data[CTL_RESET_BIT]))
			pix_reset_nxt = 1'b1;
	end

	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked)
			o_pix_reset <= 1'b1;
		else
			o_pix_reset <= pix_reset_nxt;
	end

	////////////////////
	// Reads and ack
	////////////////////

	always_comb begin
		rd_data = '0;
		case (addr)
		ADR_CONTROL: begin
			rd_data[CTL_RESET_BIT]              = pix_req;
			rd_data[CTL_LOCKED_BIT]             = locked_sys;
			rd_data[CTL_CKSEL_LSB +: CKSEL_W]   = o_pxclk_sel;
		end
		ADR_SIZE: begin
			rd_data[HFIELD_LSB +: LGDIM] = o_h_width;
			rd_data[VFIELD_LSB +: LGDIM] = o_v_height;
		end
		ADR_PORCH: begin
			rd_data[HFIELD_LSB +: LGDIM] = o_h_front;
			rd_data[VFIELD_LSB +: LGDIM] = o_v_front;
		end
		ADR_SYNC: begin
			rd_data[HFIELD_LSB +: LGDIM] = o_h_synch;
			rd_data[VFIELD_LSB +: LGDIM] = o_v_synch;
			rd_data[HPOL_BIT]            = o_h_syncpol;
			rd_data[VPOL_BIT]            = o_v_syncpol;
		end
		ADR_RAW: begin
			rd_data[HFIELD_LSB +: LGDIM] = o_h_raw;
			rd_data[VFIELD_LSB +: LGDIM] = o_v_raw;
		end
		ADR_FPS:
			rd_data[FPS_W-1:0] = i_fps;
		default: begin
		end
		endcase
	end

	// Sampled on the strobe, presented with ack
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			pre_data  <= '0;
			o_wb_data <= '0;
		end else begin
			if (i_wb_stb && !i_wb_we)
				pre_data <= rd_data;
			if (pre_ack)
				o_wb_data <= pre_data;
		end
	end

	assign o_wb_stall = 1'b0;

	// Two stage ack, flushed when cyc drops
	always_ff @(posedge i_clk or negedge i_pxpll_locked) begin
		if (!i_pxpll_locked) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else if (!i_wb_cyc) begin
			pre_ack  <= 1'b0;
			o_wb_ack <= 1'b0;
		end else begin
			pre_ack  <= i_wb_stb;
			o_wb_ack <= pre_ack;
		end
	end

endmodule

`default_nettype wire

// ==== src/vid_pkg.sv ====
/* Shared widths, register map and field positions of the video mode controller.
   TICK_CYCLES is shortened for simulation; scale it to the real clock for hardware. */
`default_nettype none

package vid_pkg;

	////////////////////
	// Widths
	////////////////////

	// Screen dimension fields, up to 4095
	localparam int LGDIM   = 12;
	localparam int WB_DW   = 32;
	localparam int WB_SELW = WB_DW / 8;
	// Word addressed register space
	localparam int ADDR_W  = 5;
	localparam int CKSEL_W = 2;
	localparam int FPS_W   = 8;

	////////////////////
	// Register map
	////////////////////

	// Unlisted addresses read zero and ignore writes
	typedef enum logic [ADDR_W-1:0] {
		ADR_CONTROL = 5'h00,
		ADR_SIZE    = 5'h08,
		ADR_PORCH   = 5'h09,
		ADR_SYNC    = 5'h0a,
		ADR_RAW     = 5'h0b,
		ADR_FPS     = 5'h0f
	} reg_addr_t;

	// Horizontal and vertical halves of a dimension word
	localparam int HFIELD_LSB = 0;
	localparam int VFIELD_LSB = 16;
	// Sync polarity bits in ADR_SYNC
	localparam int HPOL_BIT   = 15;
	localparam int VPOL_BIT   = 31;

	// Control word fields
	localparam int CTL_RESET_BIT  = 0;
	localparam int CTL_LOCKED_BIT = 1;
	localparam int CTL_CKSEL_LSB  = 4;

	// Measurement interval, in clock cycles
	localparam int TICK_CYCLES = 5000;
	localparam int TICK_W      = $clog2(TICK_CYCLES);

endpackage

`default_nettype wire
